// ==== source/block_ram.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_macros.svh"

module block_ram (
	input  wire                               i_clock,
	input  wire                               i_request,
	input  wire                               i_rw,
	input  wire [$clog2(`SOC_RAM_WORDS)-1:0]  i_address,
	input  wire [`SOC_DATA_W-1:0]             i_wdata,
	output logic [`SOC_DATA_W-1:0]            o_rdata,
	output logic                              o_ready
);

	logic [`SOC_DATA_W-1:0] mem [`SOC_RAM_WORDS];
	logic access;

	// Request still high in the ready cycle is not a new access
	assign access = i_request && !o_ready;

	always_ff @(posedge i_clock) begin
		o_ready <= access;
		if (access) begin
			if (i_rw)
				mem[i_address] <= i_wdata;
			o_rdata <= mem[i_address];
		end
	end

endmodule

`default_nettype wire

// ==== source/bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_macros.svh"

module bus_arbiter (
	input  wire                    i_clock,
	input  wire                    i_reset,

	// Instruction fetch, read only
	input  wire                    i_fetch_request,
	input  wire [`SOC_DATA_W-1:0]  i_fetch_address,
	output logic [`SOC_DATA_W-1:0] o_fetch_rdata,
	output logic                   o_fetch_ready,

	// Data port
	input  wire                    i_data_request,
	input  wire                    i_data_rw,
	input  wire [`SOC_DATA_W-1:0]  i_data_address,
	input  wire [`SOC_DATA_W-1:0]  i_data_wdata,
	output logic [`SOC_DATA_W-1:0] o_data_rdata,
	output logic                   o_data_ready,

	bus_if.slave                   dma_port,
	bus_if.master                  bus,
	output bus_pkg::master_t       o_grant
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_GRANT,
		ARB_BUSY,
		ARB_DONE
	} arb_state_t;

	arb_state_t state;

	// ==================================================
	// Grant and handshake sequence
	// ==================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ARB_IDLE;
			o_grant <= bus_pkg::MASTER_NONE;
			bus.request <= 1'b0;
			o_fetch_ready <= 1'b0;
			o_data_ready <= 1'b0;
			dma_port.ready <= 1'b0;
		end else begin
			o_fetch_ready <= 1'b0;
			o_data_ready <= 1'b0;
			dma_port.ready <= 1'b0;
			case (state)
				ARB_IDLE: begin
					// Fixed priority, fetch first
					if (i_fetch_request) begin
						o_grant <= bus_pkg::MASTER_FETCH;
						state <= ARB_GRANT;
					end else if (i_data_request) begin
						o_grant <= bus_pkg::MASTER_DATA;
						state <= ARB_GRANT;
					end else if (dma_port.request) begin
						o_grant <= bus_pkg::MASTER_DMA;
						state <= ARB_GRANT;
					end
				end
				ARB_GRANT: begin
					bus.request <= 1'b1;
					state <= ARB_BUSY;
				end
				ARB_BUSY: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						o_fetch_ready <= (o_grant == bus_pkg::MASTER_FETCH);
						o_data_ready <= (o_grant == bus_pkg::MASTER_DATA);
						dma_port.ready <= (o_grant == bus_pkg::MASTER_DMA);
						state <= ARB_DONE;
					end
				end
				ARB_DONE: begin
					// One idle cycle follows before the next grant
					o_grant <= bus_pkg::MASTER_NONE;
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// ==================================================
	// Request latch and response routing
	// ==================================================
	always_ff @(posedge i_clock) begin
		if (state == ARB_IDLE) begin
			if (i_fetch_request) begin
				bus.rw <= 1'b0;
				bus.address <= i_fetch_address;
				bus.wdata <= '0;
			end else if (i_data_request) begin
				bus.rw <= i_data_rw;
				bus.address <= i_data_address;
				bus.wdata <= i_data_wdata;
			end else begin
				bus.rw <= dma_port.rw;
				bus.address <= dma_port.address;
				bus.wdata <= dma_port.wdata;
			end
		end
		if (state == ARB_BUSY && bus.ready) begin
			if (o_grant == bus_pkg::MASTER_FETCH)
				o_fetch_rdata <= bus.rdata;
			if (o_grant == bus_pkg::MASTER_DATA)
				o_data_rdata <= bus.rdata;
			if (o_grant == bus_pkg::MASTER_DMA)
				dma_port.rdata <= bus.rdata;
		end
	end

endmodule

`default_nettype wire

// ==== source/bus_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_macros.svh"

module bus_decoder (
	input  wire                                 i_clock,
	input  wire                                 i_reset,
	input  wire bus_pkg::master_t               i_grant,
	bus_if.slave                                bus,
	bus_if.master                               dma_regs,

	// Block RAM
	output logic                                o_ram_request,
	output logic                                o_ram_rw,
	output logic [$clog2(`SOC_RAM_WORDS)-1:0]   o_ram_address,
	output logic [`SOC_DATA_W-1:0]              o_ram_wdata,
	input  wire [`SOC_DATA_W-1:0]               i_ram_rdata,
	input  wire                                 i_ram_ready,

	// Control registers
	output logic                                o_ctrl_request,
	output logic                                o_ctrl_rw,
	output periph_pkg::ctrl_reg_t               o_ctrl_index,
	output logic [`SOC_DATA_W-1:0]              o_ctrl_wdata,
	input  wire [`SOC_DATA_W-1:0]               i_ctrl_rdata,
	input  wire                                 i_ctrl_ready,

	output logic                                o_bus_fault,
	output logic [`SOC_DATA_W-1:0]              o_bus_fault_address,
	output bus_pkg::master_t                    o_bus_fault_master
);

	bus_pkg::region_t region;
	logic fault_hit;
	logic fault_ready;

	always_comb begin
		case (bus.address[`SOC_DATA_W-1:`SOC_DATA_W-4])
			`SOC_REGION_RAM:  region = bus_pkg::REGION_RAM;
			`SOC_REGION_CTRL: region = bus_pkg::REGION_CTRL;
			`SOC_REGION_DMA:  region = bus_pkg::REGION_DMA;
			default:          region = bus_pkg::REGION_UNMAPPED;
		endcase
	end

	// Target requests
	assign o_ram_request = bus.request && (region == bus_pkg::REGION_RAM);
	assign o_ram_rw = bus.rw;
	assign o_ram_address = bus.address[$clog2(`SOC_RAM_WORDS)+1:2];
	assign o_ram_wdata = bus.wdata;

	assign o_ctrl_request = bus.request && (region == bus_pkg::REGION_CTRL);
	assign o_ctrl_rw = bus.rw;
	assign o_ctrl_index = periph_pkg::ctrl_reg_t'(bus.address[3:2]);
	assign o_ctrl_wdata = bus.wdata;

	assign dma_regs.request = bus.request && (region == bus_pkg::REGION_DMA);
	assign dma_regs.rw = bus.rw;
	assign dma_regs.address = bus.address;
	assign dma_regs.wdata = bus.wdata;

	// Response mux, address is held for the whole access
	always_comb begin
		case (region)
			bus_pkg::REGION_RAM: begin
				bus.rdata = i_ram_rdata;
				bus.ready = i_ram_ready;
			end
			bus_pkg::REGION_CTRL: begin
				bus.rdata = i_ctrl_rdata;
				bus.ready = i_ctrl_ready;
			end
			bus_pkg::REGION_DMA: begin
				bus.rdata = dma_regs.rdata;
				bus.ready = dma_regs.ready;
			end
			default: begin
				bus.rdata = '0;
				bus.ready = fault_ready;
			end
		endcase
	end

	// ==================================================
	// Unmapped access completion and fault capture
	// ==================================================
	assign fault_hit = bus.request && (region == bus_pkg::REGION_UNMAPPED) && !fault_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			fault_ready <= 1'b0;
		else
			fault_ready <= fault_hit;
	end

	always_ff @(posedge i_clock) begin
		if (fault_hit) begin
			o_bus_fault_address <= bus.address;
			o_bus_fault_master <= i_grant;
		end
	end

	assign o_bus_fault = fault_ready;

endmodule

`default_nettype wire

// ==== source/bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_macros.svh"

interface bus_if;

	logic request;
	// High for a write
	logic rw;
	logic [`SOC_DATA_W-1:0] address;
	logic [`SOC_DATA_W-1:0] wdata;
	logic [`SOC_DATA_W-1:0] rdata;
	logic ready;

	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input  rdata,
		input  ready
	);

	modport slave (
		input  request,
		input  rw,
		input  address,
		input  wdata,
		output rdata,
		output ready
	);

endinterface

`default_nettype wire

// ==== source/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	// Who owns the shared bus, same code as the fault type
	typedef enum logic [1:0] {
		MASTER_NONE  = 2'd0,
		MASTER_FETCH = 2'd1,
		MASTER_DATA  = 2'd2,
		MASTER_DMA   = 2'd3
	} master_t;

	// Target picked by the top address nibble
	typedef enum logic [1:0] {
		REGION_RAM,
		REGION_CTRL,
		REGION_DMA,
		REGION_UNMAPPED
	} region_t;

endpackage

`default_nettype wire

// ==== source/control_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_macros.svh"

module control_regs (
	input  wire                         i_clock,
	input  wire                         i_reset,
	input  wire                         i_request,
	input  wire                         i_rw,
	input  wire periph_pkg::ctrl_reg_t  i_index,
	input  wire [`SOC_DATA_W-1:0]       i_wdata,
	output logic [`SOC_DATA_W-1:0]      o_rdata,
	output logic                        o_ready,
	output logic [`SOC_LED_W-1:0]       o_ledr,
	output logic                        o_timer_interrupt
);

	logic [`SOC_DATA_W-1:0] count;
	logic [`SOC_DATA_W-1:0] compare;
	logic timer_enable;
	logic access;
	logic write;
	logic ack;

	assign access = i_request && !o_ready;
	assign write = access && i_rw;
	assign ack = write && (i_index == periph_pkg::CTRL_TIMER_CTRL) &&
		i_wdata[`SOC_TIMER_ACK_BIT];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_ledr <= '0;
			count <= '0;
			compare <= '0;
			timer_enable <= 1'b0;
			o_timer_interrupt <= 1'b0;
		end else begin
			o_ready <= access;
			count <= count + 1'b1;
			if (write) begin
				case (i_index)
					periph_pkg::CTRL_LED:        o_ledr <= i_wdata[`SOC_LED_W-1:0];
					periph_pkg::CTRL_COUNT:      count <= i_wdata;
					periph_pkg::CTRL_COMPARE:    compare <= i_wdata;
					periph_pkg::CTRL_TIMER_CTRL: timer_enable <= i_wdata[`SOC_TIMER_ENABLE_BIT];
				endcase
			end
			// Level interrupt, held until acknowledged
			if (ack)
				o_timer_interrupt <= 1'b0;
			else if (timer_enable && count == compare)
				o_timer_interrupt <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			case (i_index)
				periph_pkg::CTRL_LED:
					o_rdata <= {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, o_ledr};
				periph_pkg::CTRL_COUNT:
					o_rdata <= count;
				periph_pkg::CTRL_COMPARE:
					o_rdata <= compare;
				periph_pkg::CTRL_TIMER_CTRL:
					o_rdata <= {{(`SOC_DATA_W-2){1'b0}}, o_timer_interrupt, timer_enable};
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/dma_engine.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_macros.svh"

module dma_engine (
	input  wire    i_clock,
	input  wire    i_reset,
	bus_if.slave   regs,
	bus_if.master  bus
);

	periph_pkg::dma_state_t state;
	logic [`SOC_DATA_W-1:0] src;
	logic [`SOC_DATA_W-1:0] dst;
	logic [`SOC_DATA_W-1:0] len;
	logic [`SOC_DATA_W-1:0] word;
	logic busy;
	logic reg_access;
	logic reg_write;

	assign busy = (state != periph_pkg::DMA_IDLE);
	assign reg_access = regs.request && !regs.ready;
	assign reg_write = reg_access && regs.rw;

	// ==================================================
	// Register port
	// ==================================================
	always_ff @(posedge i_clock) begin
		if (i_reset)
			regs.ready <= 1'b0;
		else
			regs.ready <= reg_access;
	end

	always_ff @(posedge i_clock) begin
		if (reg_access) begin
			case (regs.address[3:2])
				`SOC_REG_DMA_SRC: regs.rdata <= src;
				`SOC_REG_DMA_DST: regs.rdata <= dst;
				`SOC_REG_DMA_LEN: regs.rdata <= len;
				`SOC_REG_DMA_GO:  regs.rdata <= {{(`SOC_DATA_W-1){1'b0}}, busy};
			endcase
		end
	end

	// ==================================================
	// Copy sequence, one word read then written
	// ==================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= periph_pkg::DMA_IDLE;
			bus.request <= 1'b0;
			src <= '0;
			dst <= '0;
			len <= '0;
		end else begin
			case (state)
				periph_pkg::DMA_IDLE: begin
					// Setup only while idle
					if (reg_write) begin
						case (regs.address[3:2])
							`SOC_REG_DMA_SRC: src <= regs.wdata;
							`SOC_REG_DMA_DST: dst <= regs.wdata;
							`SOC_REG_DMA_LEN: len <= regs.wdata;
							`SOC_REG_DMA_GO: begin
								if (len != '0)
									state <= periph_pkg::DMA_READ;
							end
						endcase
					end
				end
				periph_pkg::DMA_READ: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						state <= periph_pkg::DMA_WRITE;
					end else begin
						bus.request <= 1'b1;
					end
				end
				periph_pkg::DMA_WRITE: begin
					if (bus.ready) begin
						bus.request <= 1'b0;
						src <= src + 4;
						dst <= dst + 4;
						len <= len - 1'b1;
						state <= (len == 1) ? periph_pkg::DMA_DONE : periph_pkg::DMA_READ;
					end else begin
						bus.request <= 1'b1;
					end
				end
				periph_pkg::DMA_DONE: begin
					state <= periph_pkg::DMA_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == periph_pkg::DMA_READ && bus.ready)
			word <= bus.rdata;
	end

	assign bus.rw = (state == periph_pkg::DMA_WRITE);
	assign bus.address = (state == periph_pkg::DMA_WRITE) ? dst : src;
	assign bus.wdata = word;

endmodule

`default_nettype wire

// ==== source/periph_pkg.sv ====
`default_nettype none
`include "soc_macros.svh"

package periph_pkg;

	// Copy engine sequence
	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_WRITE,
		DMA_DONE
	} dma_state_t;

	// Control block registers, by word offset
	typedef enum logic [1:0] {
		CTRL_LED        = `SOC_REG_LED,
		CTRL_COUNT      = `SOC_REG_COUNT,
		CTRL_COMPARE    = `SOC_REG_COMPARE,
		CTRL_TIMER_CTRL = `SOC_REG_TIMER_CTRL
	} ctrl_reg_t;

endpackage

`default_nettype wire

// ==== source/soc_macros.svh ====
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus word and address width
`define SOC_DATA_W 32

// Top address nibble per target
`define SOC_REGION_RAM  4'h1
`define SOC_REGION_CTRL 4'h4
`define SOC_REGION_DMA  4'h9

// Block RAM depth in words
`define SOC_RAM_WORDS 512

// LED register width
`define SOC_LED_W 10

// Control block word offsets
`define SOC_REG_LED        2'd0
`define SOC_REG_COUNT      2'd1
`define SOC_REG_COMPARE    2'd2
`define SOC_REG_TIMER_CTRL 2'd3

// DMA block word offsets
`define SOC_REG_DMA_SRC 2'd0
`define SOC_REG_DMA_DST 2'd1
`define SOC_REG_DMA_LEN 2'd2
`define SOC_REG_DMA_GO  2'd3

// Bits of timer_ctrl
`define SOC_TIMER_ENABLE_BIT 0
`define SOC_TIMER_ACK_BIT    1

`endif

// ==== source/soc_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_macros.svh"

module soc_top (
	input  wire                     i_clock,
	input  wire                     i_reset,

	// Instruction fetch port
	input  wire                     i_fetch_request,
	input  wire [`SOC_DATA_W-1:0]   i_fetch_address,
	output wire [`SOC_DATA_W-1:0]   o_fetch_rdata,
	output wire                     o_fetch_ready,

	// Data port
	input  wire                     i_data_request,
	input  wire                     i_data_rw,
	input  wire [`SOC_DATA_W-1:0]   i_data_address,
	input  wire [`SOC_DATA_W-1:0]   i_data_wdata,
	output wire [`SOC_DATA_W-1:0]   o_data_rdata,
	output wire                     o_data_ready,

	output wire [`SOC_LED_W-1:0]    o_ledr,
	output wire                     o_timer_interrupt,
	output wire                     o_bus_fault,
	output wire [`SOC_DATA_W-1:0]   o_bus_fault_address,
	output wire [1:0]               o_bus_fault_master
);

	bus_if dma_bus ();
	bus_if sys_bus ();
	bus_if dma_regs ();

	bus_pkg::master_t grant;
	bus_pkg::master_t fault_master;

	logic ram_request;
	logic ram_rw;
	logic [$clog2(`SOC_RAM_WORDS)-1:0] ram_address;
	logic [`SOC_DATA_W-1:0] ram_wdata;
	logic [`SOC_DATA_W-1:0] ram_rdata;
	logic ram_ready;

	logic ctrl_request;
	logic ctrl_rw;
	periph_pkg::ctrl_reg_t ctrl_index;
	logic [`SOC_DATA_W-1:0] ctrl_wdata;
	logic [`SOC_DATA_W-1:0] ctrl_rdata;
	logic ctrl_ready;

	assign o_bus_fault_master = fault_master;

	// ==================================================
	// Bus
	// ==================================================
	bus_arbiter u_arbiter (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_fetch_request (i_fetch_request),
		.i_fetch_address (i_fetch_address),
		.o_fetch_rdata   (o_fetch_rdata),
		.o_fetch_ready   (o_fetch_ready),
		.i_data_request  (i_data_request),
		.i_data_rw       (i_data_rw),
		.i_data_address  (i_data_address),
		.i_data_wdata    (i_data_wdata),
		.o_data_rdata    (o_data_rdata),
		.o_data_ready    (o_data_ready),
		.dma_port        (dma_bus.slave),
		.bus             (sys_bus.master),
		.o_grant         (grant)
	);

	bus_decoder u_decoder (
		.i_clock             (i_clock),
		.i_reset             (i_reset),
		.i_grant             (grant),
		.bus                 (sys_bus.slave),
		.dma_regs            (dma_regs.master),
		.o_ram_request       (ram_request),
		.o_ram_rw            (ram_rw),
		.o_ram_address       (ram_address),
		.o_ram_wdata         (ram_wdata),
		.i_ram_rdata         (ram_rdata),
		.i_ram_ready         (ram_ready),
		.o_ctrl_request      (ctrl_request),
		.o_ctrl_rw           (ctrl_rw),
		.o_ctrl_index        (ctrl_index),
		.o_ctrl_wdata        (ctrl_wdata),
		.i_ctrl_rdata        (ctrl_rdata),
		.i_ctrl_ready        (ctrl_ready),
		.o_bus_fault         (o_bus_fault),
		.o_bus_fault_address (o_bus_fault_address),
		.o_bus_fault_master  (fault_master)
	);

	// ==================================================
	// Targets
	// ==================================================
	block_ram u_ram (
		.i_clock   (i_clock),
		.i_request (ram_request),
		.i_rw      (ram_rw),
		.i_address (ram_address),
		.i_wdata   (ram_wdata),
		.o_rdata   (ram_rdata),
		.o_ready   (ram_ready)
	);

	control_regs u_ctrl (
		.i_clock           (i_clock),
		.i_reset           (i_reset),
		.i_request         (ctrl_request),
		.i_rw              (ctrl_rw),
		.i_index           (ctrl_index),
		.i_wdata           (ctrl_wdata),
		.o_rdata           (ctrl_rdata),
		.o_ready           (ctrl_ready),
		.o_ledr            (o_ledr),
		.o_timer_interrupt (o_timer_interrupt)
	);

	// Slave on the decoder side, master on the arbiter side
	dma_engine u_dma (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.regs    (dma_regs.slave),
		.bus     (dma_bus.master)
	);

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/bus_pkg.sv
source/periph_pkg.sv
source/bus_if.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/block_ram.sv
source/control_regs.sv
source/dma_engine.sv
source/soc_top.sv
tests/soc_tb.sv

// ==== tests/soc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "soc_macros.svh"

module soc_tb;

	localparam int max_steps = 64;
	localparam logic [31:0] ctrl_base = {`SOC_REGION_CTRL, 28'h0};
	localparam logic [31:0] dma_base = {`SOC_REGION_DMA, 28'h0};
	localparam logic [31:0] led_address = ctrl_base + 4 * `SOC_REG_LED;

	logic i_clock;
	logic i_reset;
	logic i_fetch_request;
	logic [`SOC_DATA_W-1:0] i_fetch_address;
	wire [`SOC_DATA_W-1:0] o_fetch_rdata;
	wire o_fetch_ready;
	logic i_data_request;
	logic i_data_rw;
	logic [`SOC_DATA_W-1:0] i_data_address;
	logic [`SOC_DATA_W-1:0] i_data_wdata;
	wire [`SOC_DATA_W-1:0] o_data_rdata;
	wire o_data_ready;
	wire [`SOC_LED_W-1:0] o_ledr;
	wire o_timer_interrupt;
	wire o_bus_fault;
	wire [`SOC_DATA_W-1:0] o_bus_fault_address;
	wire [1:0] o_bus_fault_master;

	// One entry per trace line
	string step_name [max_steps];
	string step_op [max_steps];
	string step_port [max_steps];
	logic [31:0] step_address [max_steps];
	logic [31:0] step_data [max_steps];
	logic [31:0] step_expected [max_steps];
	int step_count;

	// Words written to the RAM so far by byte address
	logic [31:0] shadow [logic [31:0]];

	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 0;
	int unsigned fault_pulses = 0;

	soc_top u_dut (
		.i_clock             (i_clock),
		.i_reset             (i_reset),
		.i_fetch_request     (i_fetch_request),
		.i_fetch_address     (i_fetch_address),
		.o_fetch_rdata       (o_fetch_rdata),
		.o_fetch_ready       (o_fetch_ready),
		.i_data_request      (i_data_request),
		.i_data_rw           (i_data_rw),
		.i_data_address      (i_data_address),
		.i_data_wdata        (i_data_wdata),
		.o_data_rdata        (o_data_rdata),
		.o_data_ready        (o_data_ready),
		.o_ledr              (o_ledr),
		.o_timer_interrupt   (o_timer_interrupt),
		.o_bus_fault         (o_bus_fault),
		.o_bus_fault_address (o_bus_fault_address),
		.o_bus_fault_master  (o_bus_fault_master)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	always @(posedge i_clock) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count >= cycle_limit)
			report_failure("the run timed out before the trace was finished");
	end

	// Count one-cycle fault pulses on the falling edge
	always @(negedge i_clock) begin
		if (o_bus_fault)
			fault_pulses <= fault_pulses + 1;
	end

	// ==================================================
	// Reporting
	// ==================================================
	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			report_failure($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
	endtask

	function automatic logic region_is_mapped(input logic [31:0] address);
		logic [3:0] nibble;
		nibble = address[31:28];
		return nibble == `SOC_REGION_RAM || nibble == `SOC_REGION_CTRL ||
			nibble == `SOC_REGION_DMA;
	endfunction

	// ==================================================
	// Trace file
	// ==================================================
	task automatic read_trace();
		int fd;
		int fields;
		logic [1023:0] line;
		logic [191:0] name_buf;
		logic [63:0] op_buf;
		logic [63:0] port_buf;
		logic [31:0] address;
		logic [31:0] data;
		logic [31:0] expected;
		step_count = 0;
		fd = $fopen("tests/soc_trace.txt", "r");
		if (fd == 0) begin
			report_failure("could not open the trace file tests/soc_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				if ($fgets(line, fd) != 0) begin
					fields = $sscanf(line, "%s %s %s %h %h %h", name_buf, op_buf, port_buf,
						address, data, expected);
					// Comment lines never give all six fields
					if (fields == 6 && step_count < max_steps) begin
						step_name[step_count] = $sformatf("%0s", name_buf);
						step_op[step_count] = $sformatf("%0s", op_buf);
						step_port[step_count] = $sformatf("%0s", port_buf);
						step_address[step_count] = address;
						step_data[step_count] = data;
						step_expected[step_count] = expected;
						step_count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ==================================================
	// Bus access on one port
	// ==================================================
	task automatic bus_access(input logic use_fetch, input logic rw, input logic [31:0] address,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(negedge i_clock);
		if (use_fetch) begin
			i_fetch_request = 1'b1;
			i_fetch_address = address;
		end else begin
			i_data_request = 1'b1;
			i_data_rw = rw;
			i_data_address = address;
			i_data_wdata = wdata;
		end
		do begin
			@(negedge i_clock);
		end while (!(use_fetch ? o_fetch_ready : o_data_ready));
		rdata = use_fetch ? o_fetch_rdata : o_data_rdata;
		if (use_fetch) begin
			i_fetch_request = 1'b0;
		end else begin
			i_data_request = 1'b0;
			i_data_rw = 1'b0;
		end
	endtask

	// Unmapped accesses must fault once and name the address and master
	task automatic access_checked(input string name, input logic use_fetch, input logic rw,
		input logic [31:0] address, input logic [31:0] wdata, output logic [31:0] rdata);
		int unsigned pulses_before;
		logic [1:0] master;
		pulses_before = fault_pulses;
		master = use_fetch ? bus_pkg::MASTER_FETCH : bus_pkg::MASTER_DATA;
		bus_access(use_fetch, rw, address, wdata, rdata);
		if (region_is_mapped(address)) begin
			check_equal({name, " fault count"}, 0, fault_pulses - pulses_before);
		end else begin
			check_equal({name, " fault count"}, 1, fault_pulses - pulses_before);
			check_equal({name, " fault address"}, address, o_bus_fault_address);
			check_equal({name, " fault master"}, master, o_bus_fault_master);
		end
	endtask

	task automatic run_dma(input string name, input logic [31:0] src, input logic [31:0] dst,
		input logic [31:0] words);
		logic [31:0] unused;
		logic [31:0] busy;
		logic [31:0] src_word;
		logic [31:0] dst_word;
		logic [31:0] expected_word;
		int polls;
		bus_access(1'b0, 1'b1, dma_base + 4 * `SOC_REG_DMA_SRC, src, unused);
		bus_access(1'b0, 1'b1, dma_base + 4 * `SOC_REG_DMA_DST, dst, unused);
		bus_access(1'b0, 1'b1, dma_base + 4 * `SOC_REG_DMA_LEN, words, unused);
		bus_access(1'b0, 1'b1, dma_base + 4 * `SOC_REG_DMA_GO, 32'd1, unused);
		busy = 32'd1;
		polls = 0;
		// Gaps between polls let the engine win the bus
		while (busy != 0 && polls < 4 * words + 4) begin
			repeat (8) @(negedge i_clock);
			bus_access(1'b0, 1'b0, dma_base + 4 * `SOC_REG_DMA_GO, 32'd0, busy);
			polls++;
		end
		check_equal({name, " busy"}, 0, busy);
		for (int i = 0; i < words; i++) begin
			if (!shadow.exists(src + 4 * i)) begin
				report_failure({name, " copies a source word that was never written"});
			end else begin
				expected_word = shadow[src + 4 * i];
				bus_access(1'b0, 1'b0, src + 4 * i, 32'd0, src_word);
				bus_access(1'b0, 1'b0, dst + 4 * i, 32'd0, dst_word);
				check_equal($sformatf("%s source word %0d", name, i), expected_word, src_word);
				check_equal($sformatf("%s word %0d", name, i), expected_word, dst_word);
				shadow[dst + 4 * i] = expected_word;
			end
		end
	endtask

	// ==================================================
	// One trace step
	// ==================================================
	task automatic run_step(input int idx);
		string name;
		string op;
		logic use_fetch;
		logic [31:0] address;
		logic [31:0] data;
		logic [31:0] expected;
		logic [31:0] rdata;
		logic [31:0] data_rdata;
		int waited;
		name = step_name[idx];
		op = step_op[idx];
		use_fetch = (step_port[idx] == "fetch");
		address = step_address[idx];
		data = step_data[idx];
		expected = step_expected[idx];
		if (op == "write" && use_fetch) begin
			report_failure({name, " asks for a write on the read-only fetch port"});
		end else if (op == "write") begin
			access_checked(name, 1'b0, 1'b1, address, data, rdata);
			if (address[31:28] == `SOC_REGION_RAM)
				shadow[address] = data;
			if (address == led_address)
				check_equal({name, " ledr"}, expected, {{(32-`SOC_LED_W){1'b0}}, o_ledr});
		end else if (op == "read" && step_port[idx] == "both") begin
			// Fetch reads the address column and data reads the data column
			fork
				bus_access(1'b1, 1'b0, address, 32'd0, rdata);
				bus_access(1'b0, 1'b0, data, 32'd0, data_rdata);
			join
			check_equal({name, " fetch"}, expected, rdata);
			if (!shadow.exists(data))
				report_failure({name, " reads a data port address that was never written"});
			else
				check_equal({name, " data"}, shadow[data], data_rdata);
		end else if (op == "read") begin
			access_checked(name, use_fetch, 1'b0, address, 32'd0, rdata);
			check_equal(name, expected, rdata);
		end else if (op == "wait_irq") begin
			waited = 0;
			while (!o_timer_interrupt && waited < data) begin
				@(negedge i_clock);
				waited++;
			end
			check_equal({name, " interrupt"}, expected, o_timer_interrupt);
		end else if (op == "ack") begin
			access_checked(name, 1'b0, 1'b1, address, data, rdata);
			check_equal({name, " interrupt"}, expected, o_timer_interrupt);
		end else if (op == "dma") begin
			run_dma(name, address, data, expected);
		end else begin
			report_failure({name, " has an unknown operation ", op});
		end
	endtask

	initial begin
		int unsigned longest_dma;
		i_reset = 1'b1;
		i_fetch_request = 1'b0;
		i_fetch_address = '0;
		i_data_request = 1'b0;
		i_data_rw = 1'b0;
		i_data_address = '0;
		i_data_wdata = '0;
		read_trace();
		longest_dma = 0;
		for (int i = 0; i < step_count; i++) begin
			if (step_op[i] == "dma" && step_expected[i] > longest_dma)
				longest_dma = step_expected[i];
		end
		cycle_limit = step_count * 64 + longest_dma * 16;
		repeat (2) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		check_equal("reset fetch ready", 0, o_fetch_ready);
		check_equal("reset data ready", 0, o_data_ready);
		check_equal("reset bus fault", 0, o_bus_fault);
		check_equal("reset timer interrupt", 0, o_timer_interrupt);
		check_equal("reset ledr", 0, o_ledr);
		for (int i = 0; i < step_count; i++)
			run_step(i);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/soc_trace.txt ====
# columns: name op port address data expected, numbers in hex
# a dma step copies from address to data for expected words, a both step reads data on the data port
dma_idle      read     data   9000000C 00000000 00000000
ram_w0        write    data   10000000 CAFE0001 00000000
ram_w1        write    data   10000004 12345678 00000000
ram_w2        write    data   10000008 A5A5A5A5 00000000
ram_w3        write    data   1000000C 0F0F0F0F 00000000
ram_w_last    write    data   100007FC DEADBEEF 00000000
ram_rd_data   read     data   10000004 00000000 12345678
ram_rd_fetch  read     fetch  10000008 00000000 A5A5A5A5
ram_rd_last   read     fetch  100007FC 00000000 DEADBEEF
dual_read     read     both   1000000C 10000000 0F0F0F0F
led_write     write    data   40000000 FFFFFABC 000002BC
led_read      read     data   40000000 00000000 000002BC
count_clear   write    data   40000004 00000000 00000000
compare_set   write    data   40000008 00000030 00000000
timer_on      write    data   4000000C 00000001 00000000
irq_rise      wait_irq data   00000000 00000040 00000001
irq_ack       ack      data   4000000C 00000002 00000000
dma_copy      dma      data   10000000 10000100 00000004
dma_busy      read     data   9000000C 00000000 00000000
copy_check    read     fetch  1000010C 00000000 0F0F0F0F
fault_data    read     data   20000010 00000000 00000000
fault_fetch   read     fetch  F0000104 00000000 00000000
ram_intact    read     data   10000000 00000000 CAFE0001
